// File: corr_pkg.sv
// Sizes are fixed at compile time; base_i and base_j must list NUM_BASELINES distinct pairs.
`default_nettype none

package corr_pkg;

	localparam int NUM_INPUTS = 4;
	localparam int TAP_DEPTH = 3; // Tap 0 holds the newest sample.
	localparam int REF_TAP = 1; // The first input of a baseline is always taken from this tap.
	localparam int NUM_BASELINES = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int NUM_LAGS = TAP_DEPTH;
	localparam int NUM_BINS = NUM_BASELINES * NUM_LAGS;
	localparam int ADDR_WIDTH = 5;
	localparam int COUNT_WIDTH = 8;
	localparam int COUNT_MAX = (1 << COUNT_WIDTH) - 1;
	localparam int LEN_WIDTH = 16;

	// Baseline b correlates input base_i[b] against input base_j[b].
	localparam int base_i [NUM_BASELINES] = '{0, 0, 0, 1, 1, 2};
	localparam int base_j [NUM_BASELINES] = '{1, 2, 3, 2, 3, 3};

	typedef enum logic [1:0] {
		CMD_NOP = 2'd0,
		CMD_START = 2'd1,
		CMD_STOP = 2'd2,
		CMD_CLEAR = 2'd3
	} cmd_t;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_INTEGRATE = 2'd1,
		ST_DONE = 2'd2
	} state_t;

	// Counter address of a baseline and lag pair.
	function automatic int bin_addr(input int baseline, input int lag);
		return baseline * NUM_LAGS + lag;
	endfunction

endpackage

`default_nettype wire

// File: corr_ctrl.sv
// A length of zero never completes integration; leave it with CMD_STOP or CMD_CLEAR.
`default_nettype none

module corr_ctrl (
	input wire logic clk,
	input wire logic rst,
	input wire corr_pkg::cmd_t cmd,
	input wire logic [corr_pkg::LEN_WIDTH-1:0] int_len,
	input wire logic match_valid,
	output logic frame_accept,
	output logic acc_clear,
	output logic busy,
	output logic done
);
	import corr_pkg::*;

	state_t state;
	logic [LEN_WIDTH-1:0] len_q;
	logic [LEN_WIDTH-1:0] frame_cnt;
	logic last_frame;

	// A frame counts only while integrating and below the latched length.
	assign frame_accept = match_valid && (state == ST_INTEGRATE) && (frame_cnt < len_q);
	assign last_frame = (frame_cnt + 1'b1) == len_q;

	assign busy = (state == ST_INTEGRATE);
	assign done = (state == ST_DONE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			frame_cnt <= '0;
			acc_clear <= 1'b0;
		end else begin
			acc_clear <= 1'b0;

			if (frame_accept) begin
				frame_cnt <= frame_cnt + 1'b1;
				if (last_frame) begin
					state <= ST_DONE; // The last add lands on this same edge.
				end
			end

			// Commands are applied last so that they win over the frame count.
			case (cmd)
				CMD_START: begin
					if (state != ST_INTEGRATE) begin
						state <= ST_INTEGRATE;
						frame_cnt <= '0;
					end
				end
				CMD_STOP: begin
					state <= ST_IDLE;
				end
				CMD_CLEAR: begin
					state <= ST_IDLE;
					acc_clear <= 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

	// The length is only meaningful once a start has been taken.
	always_ff @(posedge clk) begin
		if (cmd == CMD_START && state != ST_INTEGRATE) begin
			len_q <= int_len;
		end
	end

endmodule

`default_nettype wire

// File: sample_delay.sv
// Samples shift only on a strobe; between strobes the taps hold their last frame.
`default_nettype none

module sample_delay (
	input wire logic clk,
	input wire logic rst,
	input wire logic smp_strobe,
	input wire logic [corr_pkg::NUM_INPUTS-1:0] samples,
	output logic [corr_pkg::NUM_INPUTS-1:0][corr_pkg::TAP_DEPTH-1:0] taps
);
	import corr_pkg::*;

	// One delay line per input, newest sample enters at tap 0.
	always_ff @(posedge clk) begin
		if (rst) begin
			taps <= '0;
		end else if (smp_strobe) begin
			for (int i = 0; i < NUM_INPUTS; i++) begin
				taps[i] <= {taps[i][TAP_DEPTH-2:0], samples[i]};
			end
		end
	end

endmodule

`default_nettype wire

// File: lag_multiplier.sv
// Match bits are valid only in the cycle where match_valid is high.
`default_nettype none

module lag_multiplier (
	input wire logic clk,
	input wire logic rst,
	input wire logic smp_strobe,
	input wire logic [corr_pkg::NUM_INPUTS-1:0][corr_pkg::TAP_DEPTH-1:0] taps,
	output logic [corr_pkg::NUM_BINS-1:0] match,
	output logic match_valid
);
	import corr_pkg::*;

	logic strobe_q;
	logic [NUM_BINS-1:0] match_next;

	// One-bit product: two samples agree when they carry the same sign bit.
	always_comb begin
		match_next = '0;
		for (int b = 0; b < NUM_BASELINES; b++) begin
			for (int l = 0; l < NUM_LAGS; l++) begin
				match_next[bin_addr(b, l)] = ~(taps[base_i[b]][REF_TAP] ^ taps[base_j[b]][l]);
			end
		end
	end

	// The delayed strobe marks the cycle after the shift, when taps hold the new frame.
	always_ff @(posedge clk) begin
		if (rst) begin
			strobe_q <= 1'b0;
			match_valid <= 1'b0;
		end else begin
			strobe_q <= smp_strobe;
			match_valid <= strobe_q;
		end
	end

	always_ff @(posedge clk) begin
		if (strobe_q) begin
			match <= match_next;
		end
	end

endmodule

`default_nettype wire

// File: corr_accumulators.sv
// Counters stick at COUNT_MAX until cleared; a read returns the value before any add on that edge.
`default_nettype none

module corr_accumulators (
	input wire logic clk,
	input wire logic rst,
	input wire logic [corr_pkg::NUM_BINS-1:0] match,
	input wire logic frame_accept,
	input wire logic acc_clear,
	input wire logic rd_en,
	input wire logic [corr_pkg::ADDR_WIDTH-1:0] rd_addr,
	output logic [corr_pkg::COUNT_WIDTH-1:0] rd_data,
	output logic rd_valid
);
	import corr_pkg::*;

	logic [COUNT_WIDTH-1:0] count [NUM_BINS];
	logic [COUNT_WIDTH-1:0] rd_mux;

	// Each bin adds its own agreement bit for an accepted frame.
	always_ff @(posedge clk) begin
		if (rst || acc_clear) begin
			for (int b = 0; b < NUM_BINS; b++) begin
				count[b] <= '0;
			end
		end else if (frame_accept) begin
			for (int b = 0; b < NUM_BINS; b++) begin
				if (match[b] && (count[b] != COUNT_WIDTH'(COUNT_MAX))) begin
					count[b] <= count[b] + 1'b1;
				end
			end
		end
	end

	// Addresses past the last bin read as zero.
	always_comb begin
		rd_mux = '0;
		for (int b = 0; b < NUM_BINS; b++) begin
			if (rd_addr == ADDR_WIDTH'(b)) begin
				rd_mux = count[b];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_en;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= rd_mux;
		end
	end

endmodule

`default_nettype wire

// File: corr_top.sv
// No back-pressure: every strobe is taken, and frames outside integration are shifted but not counted.
`default_nettype none

module corr_top (
	input wire logic clk,
	input wire logic rst,
	input wire corr_pkg::cmd_t cmd,
	input wire logic [corr_pkg::LEN_WIDTH-1:0] int_len,
	input wire logic smp_strobe,
	input wire logic [corr_pkg::NUM_INPUTS-1:0] samples,
	input wire logic rd_en,
	input wire logic [corr_pkg::ADDR_WIDTH-1:0] rd_addr,
	output logic [corr_pkg::COUNT_WIDTH-1:0] rd_data,
	output logic rd_valid,
	output logic busy,
	output logic done
);
	import corr_pkg::*;

	logic [NUM_INPUTS-1:0][TAP_DEPTH-1:0] taps;
	logic [NUM_BINS-1:0] match;
	logic match_valid;
	logic frame_accept;
	logic acc_clear;

	corr_ctrl ctrl0 (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.int_len(int_len),
		.match_valid(match_valid),
		.frame_accept(frame_accept),
		.acc_clear(acc_clear),
		.busy(busy),
		.done(done)
	);

	sample_delay delay0 (
		.clk(clk),
		.rst(rst),
		.smp_strobe(smp_strobe),
		.samples(samples),
		.taps(taps)
	);

	lag_multiplier mult0 (
		.clk(clk),
		.rst(rst),
		.smp_strobe(smp_strobe),
		.taps(taps),
		.match(match),
		.match_valid(match_valid)
	);

	corr_accumulators acc0 (
		.clk(clk),
		.rst(rst),
		.match(match),
		.frame_accept(frame_accept),
		.acc_clear(acc_clear),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.rd_valid(rd_valid)
	);

endmodule

`default_nettype wire

// File: tb_clock.sv
// Free-running clock with a period of 20 time units, starting low.
`default_nettype none

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always begin
		#10 clk = ~clk; // Half period.
	end

endmodule

`default_nettype wire

// File: corr_asserts.sv
// Bound into corr_ctrl; checks hold only while rst is low.
`default_nettype none

module corr_asserts (
	input wire logic clk,
	input wire logic rst,
	input wire corr_pkg::cmd_t cmd,
	input wire logic busy,
	input wire logic done,
	input wire logic frame_accept,
	input wire logic acc_clear
);
	import corr_pkg::*;

	busy_done_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(busy && done))
		else $error("busy and done are both high");

	accept_needs_busy: assert property (@(posedge clk) disable iff (rst)
		frame_accept |-> busy)
		else $error("frame_accept is high outside integration");

	clear_one_cycle: assert property (@(posedge clk) disable iff (rst)
		acc_clear |=> !acc_clear)
		else $error("acc_clear lasted more than one cycle");

	done_falls_on_cmd: assert property (@(posedge clk) disable iff (rst)
		$fell(done) |-> ($past(cmd) != CMD_NOP))
		else $error("done fell without a command");

endmodule

bind corr_ctrl corr_asserts ctrl_asserts0 (
	.clk(clk),
	.rst(rst),
	.cmd(cmd),
	.busy(busy),
	.done(done),
	.frame_accept(frame_accept),
	.acc_clear(acc_clear)
);

`default_nettype wire

// File: corr_tb.sv
// Runs from the project root so that corr_golden.txt is found; the phase list ends with tag 0.
`default_nettype none

module corr_tb;
	import corr_pkg::*;

	localparam int GOLDEN_WORDS = 128;
	localparam int WAIT_LIMIT = 2000;

	logic clk;
	logic rst;
	cmd_t cmd;
	logic [LEN_WIDTH-1:0] int_len;
	logic smp_strobe;
	logic [NUM_INPUTS-1:0] samples;
	logic rd_en;
	logic [ADDR_WIDTH-1:0] rd_addr;
	logic [COUNT_WIDTH-1:0] rd_data;
	logic rd_valid;
	logic busy;
	logic done;

	logic [15:0] golden [0:GOLDEN_WORDS-1];
	logic [31:0] rng_state;
	int error_count;
	int timeout_count;
	int check_count_total;
	int ptr;

	tb_clock clock0 (
		.clk(clk)
	);

	corr_top dut0 (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.int_len(int_len),
		.smp_strobe(smp_strobe),
		.samples(samples),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.busy(busy),
		.done(done)
	);

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Inputs change a short time after the rising edge.
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic send_cmd(input cmd_t c);
		cmd = c;
		step();
		cmd = CMD_NOP;
	endtask

	task automatic send_frame(input logic [NUM_INPUTS-1:0] value);
		int gap;
		smp_strobe = 1'b1;
		samples = value;
		step();
		smp_strobe = 1'b0;
		gap = 1 + int'(next_random() % 32'd3); // One to three cycles between strobes.
		repeat (gap - 1) step();
	endtask

	task automatic check_count(input int addr, input logic [COUNT_WIDTH-1:0] got,
		input logic [COUNT_WIDTH-1:0] expected);
		check_count_total++;
		if (got !== expected) begin
			error_count++;
			$display("Error at %0t: rd_data of bin %0d is %0d, expected %0d",
				$time, addr, got, expected);
		end
	endtask

	task automatic check_state(input logic exp_busy, input logic exp_done);
		check_count_total++;
		if (busy !== exp_busy || done !== exp_done) begin
			error_count++;
			$display("Error at %0t: busy/done is %b/%b, expected %b/%b",
				$time, busy, done, exp_busy, exp_done);
		end
	endtask

	task automatic read_bin(input int addr, output logic [COUNT_WIDTH-1:0] value);
		int waited;
		rd_en = 1'b1;
		rd_addr = ADDR_WIDTH'(addr);
		step();
		rd_en = 1'b0;
		waited = 0;
		while (!rd_valid && waited < WAIT_LIMIT) begin
			step();
			waited++;
		end
		if (!rd_valid) begin
			timeout_count++;
			$display("Timeout: no read response for address %0d", addr);
		end else if (waited != 0) begin
			error_count++;
			$display("Read response for address %0d came %0d cycles late", addr, waited);
		end
		value = rd_data;
		step();
		if (rd_valid !== 1'b0) begin
			error_count++;
			$display("Error at %0t: rd_valid is %b, expected 0 after a one-cycle response",
				$time, rd_valid);
		end
	endtask

	task automatic wait_done(input int tag);
		int waited;
		waited = 0;
		while (!done && waited < WAIT_LIMIT) begin
			step();
			waited++;
		end
		if (!done) begin
			timeout_count++;
			$display("Timeout: integration of phase %0d never finished", tag);
		end
	endtask

	// Reads every bin and compares it with the golden table, or with zero.
	task automatic check_bins(input int base, input bit expect_zero);
		logic [COUNT_WIDTH-1:0] got;
		logic [COUNT_WIDTH-1:0] expected;
		for (int a = 0; a < NUM_BINS; a++) begin
			read_bin(a, got);
			expected = expect_zero ? '0 : golden[base + a][COUNT_WIDTH-1:0];
			check_count(a, got, expected);
		end
	endtask

	task automatic run_phase();
		int tag;
		int nframes;
		int stop_after;
		int nlist;
		int list_base;
		int exp_base;
		int idx;
		tag = int'(golden[ptr]);
		nframes = int'(golden[ptr + 2]);
		stop_after = int'(golden[ptr + 3]);
		nlist = int'(golden[ptr + 4]);
		list_base = ptr + 5;
		exp_base = list_base + nlist;
		ptr = exp_base + NUM_BINS;

		send_cmd(CMD_CLEAR);
		int_len = golden[list_base - 4];
		send_cmd(CMD_START);
		for (int f = 0; f < nframes; f++) begin
			idx = (f < nlist) ? f : nlist - 1; // The last listed frame repeats.
			send_frame(golden[list_base + idx][NUM_INPUTS-1:0]);
			if (stop_after == 0 && f == 1) begin
				send_cmd(CMD_START); // Must be ignored while integrating.
			end
			if (stop_after != 0 && f == stop_after - 1) begin
				repeat (4) step();
				send_cmd(CMD_STOP);
			end
		end
		repeat (4) step();

		if (stop_after == 0) begin
			wait_done(tag);
			check_state(1'b0, 1'b1);
		end else begin
			check_state(1'b0, 1'b0);
		end
		check_bins(exp_base, 1'b0);
	endtask

	initial begin
		logic [COUNT_WIDTH-1:0] got;
		rst = 1'b1;
		cmd = CMD_NOP;
		int_len = '0;
		smp_strobe = 1'b0;
		samples = '0;
		rd_en = 1'b0;
		rd_addr = '0;
		rng_state = 32'd76;
		error_count = 0;
		timeout_count = 0;
		check_count_total = 0;
		ptr = 0;
		$readmemh("corr_golden.txt", golden);

		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		step();

		check_state(1'b0, 1'b0);
		check_bins(0, 1'b1);

		while (ptr < GOLDEN_WORDS - 5 && !$isunknown(golden[ptr]) && golden[ptr] != 16'h0) begin
			run_phase();
		end

		// Bins still hold counts here, so an aliased address would read non-zero.
		read_bin(18, got);
		check_count(18, got, '0);
		read_bin(31, got);
		check_count(31, got, '0);

		send_cmd(CMD_CLEAR);
		step();
		check_state(1'b0, 1'b0);
		check_bins(0, 1'b1);

		$display("Checks: %0d, errors: %0d, timeouts: %0d",
			check_count_total, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: corr_golden.txt
// Phase: tag, length, frames to send, stop after frame (0 = none), listed frames, frames,
// then 18 expected bin counts (bin = baseline * 3 + lag). Tag 0 ends the list. All hex.
// Phase 1: length 4, six frames, second start ignored.
0001 0004 0006 0000 0006
0001 0003 0006 000C 000F 0009
0004 0002 0001
0002 0001 0002
0001 0002 0002
0004 0003 0002
0003 0002 0002
0004 0003 0003
// Phase 2: length 8, stop after three frames, two frames after stop.
0002 0008 0005 0003 0005
0005 000A 0000 000F 0003
0002 0000 0002
0002 0002 0001
0002 0001 0003
0001 0001 0002
0001 0002 0000
0003 0000 0002
// Phase 3: length 300 of constant samples, counters saturate.
0003 012C 012E 0000 0001
0005
0000 0001 0002
00FF 00FF 00FF
0000 0000 0001
0001 0000 0002
00FF 00FF 00FF
0001 0001 0000
// End of phases.
0000

// File: verilog.f
corr_pkg.sv
corr_ctrl.sv
sample_delay.sv
lag_multiplier.sv
corr_accumulators.sv
corr_top.sv
tb_clock.sv
corr_asserts.sv
corr_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the correlator testbench with Verilator and runs it from the project root.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module corr_tb -o corr_sim

./obj_dir/corr_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
	echo "Simulation ended without a result line."
	exit 1
fi
exit 0
